// ==== sources.f ====
logic/core_pkg.sv
logic/mem_bus_if.sv
logic/data_ram.sv
logic/mem_arbiter.sv
logic/core_mul.sv
logic/core_ldst.sv
logic/core_cycles.sv
logic/core_exec_top.sv
sim/tb_core_exec.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_core_exec -f sources.f
output="$(./obj_dir/Vtb_core_exec)"
echo "$output"

if echo "$output" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
exit 1

// ==== sim/tb_core_exec.sv ====
`timescale 1ns/100ps

module tb_core_exec;
	import core_pkg::*;

	localparam int RAM_WORDS = 2 ** RAM_AW;
	localparam int N_INSTR = 200;
	// Four full-length stores write every RAM word before any load
	localparam int FILL_STORES = RAM_WORDS / 16;
	localparam int TIMEOUT_CYCLES = (N_INSTR + FILL_STORES + RAM_WORDS) *
		(16 * 4 + MUL_STEPS + 8) + 20;

	logic clk = 1'b0;
	logic rst_n;
	logic halt;
	logic mul;
	logic ldst;
	logic bubble;
	logic exception;
	logic mul_add;
	logic mul_long;
	logic trivial_shift;
	logic ldst_writeback;
	logic data_snd_shift_by_reg;
	word_t op_a;
	word_t op_b;
	dword_t acc;
	logic load;
	addr_t base;
	reg_cnt_t count;
	word_t st_data;
	logic dbg_req;
	addr_t dbg_addr;
	ctrl_cycle cycle;
	dword_t product;
	logic rd_valid;
	word_t rd_data;
	logic st_take;
	logic base_wb_valid;
	addr_t base_wb_data;
	logic dbg_ack;
	word_t dbg_rdata;

	integer seed = 32'h34347345;

	// Reference state: memory contents, expected cycle and per-instruction progress
	word_t model_mem [RAM_WORDS];
	ctrl_cycle exp_cyc;
	dword_t exp_prod;
	int words_done;
	int mul_cycles;
	int hold_left;
	int n_issued;
	logic instr_active;
	string test_name;
	int test_errs;
	int total_errs;
	int n_tests;
	int n_failed;

	core_exec_top #(.RAM_AW(RAM_AW), .MUL_STEPS(MUL_STEPS)) i_core_exec_top (
		.clk, .rst_n, .halt, .mul, .ldst, .bubble, .exception, .mul_add, .mul_long,
		.trivial_shift, .ldst_writeback, .data_snd_shift_by_reg, .op_a, .op_b, .acc,
		.load, .base, .count, .st_data, .dbg_req, .dbg_addr, .cycle, .product,
		.rd_valid, .rd_data, .st_take, .base_wb_valid, .base_wb_data, .dbg_ack, .dbg_rdata
	);

	always #2 clk = ~clk;

	function automatic int pick(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % n;
	endfunction

	function automatic logic coin();
		int r;
		r = $random(seed);
		return r[0];
	endfunction

	task automatic report_error(input string msg);
		$display("error %s: %s", test_name, msg);
		test_errs++;
	endtask

	task automatic check_cycle(input string what, input ctrl_cycle exp, input ctrl_cycle act);
		if (act !== exp) begin
			$display("mismatch %s: expected %b, actual %b", what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_word(input string what, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("mismatch %s: expected %h, actual %h", what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_dword(input string what, input dword_t exp, input dword_t act);
		if (act !== exp) begin
			$display("mismatch %s: expected %h, actual %h", what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_addr(input string what, input addr_t exp, input addr_t act);
		if (act !== exp) begin
			$display("mismatch %s: expected %h, actual %h", what, exp, act);
			test_errs++;
		end
	endtask

	task automatic finish_test();
		n_tests++;
		total_errs += test_errs;
		if (test_errs != 0) begin
			n_failed++;
			$display("test %s: failed with %0d errors", test_name, test_errs);
		end else begin
			$display("test %s: ok", test_name);
		end
		test_errs = 0;
	endtask

	// Decoder outputs with no instruction in flight
	task automatic set_idle();
		halt = 1'b0;
		mul = 1'b0;
		ldst = 1'b0;
		bubble = 1'b0;
		exception = 1'b0;
		mul_add = 1'b0;
		mul_long = 1'b0;
		trivial_shift = 1'b1;
		ldst_writeback = 1'b0;
		data_snd_shift_by_reg = 1'b0;
		load = 1'b0;
	endtask

	// Next execute cycle by the sequencing rules, from what the decoder now drives
	function automatic ctrl_cycle model_next(input ctrl_cycle cur, input logic mem_rdy,
			input logic more, input logic mul_rdy);
		ctrl_cycle nxt;
		nxt = '0;
		if (cur.issue && exception)
			nxt.exception = 1'b1;
		else if (cur.issue && halt)
			nxt.issue = 1'b1;
		else if (cur.issue && mul && mul_add)
			nxt.mul_acc_ld = 1'b1;
		else if (cur.issue && mul)
			nxt.mul = 1'b1;
		else if (cur.issue && data_snd_shift_by_reg)
			nxt.rd_indirect_shift = 1'b1;
		else if ((cur.issue || cur.rd_indirect_shift) && !trivial_shift)
			nxt.with_shift = 1'b1;
		else if (cur.transfer && (!mem_rdy || more))
			nxt.transfer = 1'b1;
		else if (cur.transfer && ldst_writeback)
			nxt.base_writeback = 1'b1;
		else if (cur.mul_acc_ld || (cur.mul && !mul_rdy))
			nxt.mul = 1'b1;
		else if (cur.mul && mul_long)
			nxt.mul_hi_wb = 1'b1;
		else
			nxt.issue = 1'b1;
		// Bubble beats everything, a pending load/store turns issue into transfer
		if (bubble) begin
			nxt = '0;
			nxt.issue = 1'b1;
		end else if (nxt.issue && ldst) begin
			nxt.issue = 1'b0;
			nxt.transfer = 1'b1;
		end
		return nxt;
	endfunction

	task automatic draw_instr();
		int cls;
		string kind;
		set_idle();
		n_issued++;
		instr_active = 1'b1;
		hold_left = 0;
		st_data = $random(seed);
		// The first instructions are fixed stores that fill the whole RAM
		cls = (n_issued <= FILL_STORES) ? 8 : pick(9);
		case (cls)
			0: kind = "plain";
			1: begin
				kind = "indirect shift";
				data_snd_shift_by_reg = 1'b1;
				trivial_shift = coin();
			end
			2: begin
				kind = "shift";
				trivial_shift = 1'b0;
			end
			3: begin
				kind = "exception";
				exception = 1'b1;
				halt = coin();
			end
			4: begin
				kind = "halt";
				halt = 1'b1;
				hold_left = pick(4);
			end
			5: begin
				kind = "bubble";
				bubble = 1'b1;
				trivial_shift = 1'b0;
				mul = coin();
			end
			6: begin
				kind = "multiply";
				mul = 1'b1;
				mul_add = coin();
				mul_long = coin();
				op_a = $random(seed);
				op_b = $random(seed);
				acc = {$random(seed), $random(seed)};
				exp_prod = dword_t'(op_a) * dword_t'(op_b);
				if (mul_add)
					exp_prod = exp_prod + acc;
			end
			default: begin
				load = (cls == 7);
				kind = load ? "load" : "store";
				ldst = 1'b1;
				base = $random(seed);
				base[1:0] = 2'b00;
				count = reg_cnt_t'(1 + pick(16));
				ldst_writeback = coin();
				// Sometimes the address goes through the shifter first
				trivial_shift = pick(4) != 0;
			end
		endcase
		if (n_issued <= FILL_STORES) begin
			kind = "fill store";
			base = addr_t'((n_issued - 1) * 64);
			count = reg_cnt_t'(16);
			ldst_writeback = 1'b0;
			trivial_shift = 1'b1;
		end
		test_name = $sformatf("%0d %s", n_issued, kind);
	endtask

	// One clock: check the outputs, then drive the decoder, then step the model
	task automatic run_cycle();
		ctrl_cycle cur;
		ctrl_cycle nxt;
		logic ack;
		logic more;
		logic mul_rdy;
		int idx;
		@(negedge clk);
		cur = exp_cyc;
		check_cycle({test_name, " cycle"}, cur, cycle);
		if ($countones(cycle) != 1)
			report_error("cycle flags are not one-hot");

		ack = rd_valid || st_take;
		more = 1'b0;
		if (ack && !cur.transfer) begin
			report_error("load/store handshake outside a transfer");
		end else if (ack) begin
			idx = (int'(base[RAM_AW+1:2]) + words_done) % RAM_WORDS;
			if (rd_valid !== load)
				report_error("handshake kind does not match the transfer direction");
			if (words_done >= int'(count))
				report_error("more words moved than the count asks for");
			if (rd_valid)
				check_word({test_name, " rd_data"}, model_mem[idx], rd_data);
			if (st_take) begin
				model_mem[idx] = st_data;
				st_data = $random(seed);
			end
			words_done++;
			more = words_done < int'(count);
		end

		mul_rdy = 1'b0;
		if (cur.mul) begin
			// The product is complete MUL_STEPS cycles after the start edge
			mul_rdy = mul_cycles == MUL_STEPS;
			mul_cycles++;
			if (mul_rdy)
				check_dword({test_name, " product"}, exp_prod, product);
		end else begin
			mul_cycles = 0;
		end
		if (cur.mul_hi_wb)
			check_word({test_name, " product high"}, exp_prod[63:32], product[63:32]);

		if (base_wb_valid !== cur.base_writeback)
			report_error("base_wb_valid does not follow the writeback cycle");
		if (cur.base_writeback)
			check_addr({test_name, " base_wb_data"}, base + (addr_t'(count) << 2),
				base_wb_data);

		if (dbg_ack) begin
			if (!dbg_req)
				report_error("dbg_ack without a debug request");
			check_word({test_name, " debug read"}, model_mem[int'(dbg_addr[RAM_AW+1:2])],
				dbg_rdata);
			dbg_req = 1'b0;
		end else if (!dbg_req && instr_active && n_issued > FILL_STORES && pick(4) == 0) begin
			dbg_req = 1'b1;
			dbg_addr = $random(seed);
			dbg_addr[1:0] = 2'b00;
		end

		if (cur.issue) begin
			if (hold_left > 0) begin
				hold_left--;
			end else begin
				if (instr_active)
					finish_test();
				instr_active = 1'b0;
				if (n_issued < N_INSTR + FILL_STORES)
					draw_instr();
				else
					set_idle();
			end
		end else begin
			// Entry flags only matter at issue, ldst until the transfer has begun
			halt = 1'b0;
			mul = 1'b0;
			bubble = 1'b0;
			exception = 1'b0;
			data_snd_shift_by_reg = 1'b0;
			if (cur.transfer)
				ldst = 1'b0;
		end

		nxt = model_next(cur, ack, more, mul_rdy);
		if (nxt.transfer && !cur.transfer)
			words_done = 0;
		exp_cyc = nxt;
	endtask

	// Every RAM word through the debug port, compared with the model memory
	task automatic read_back();
		int i;
		test_name = "readback";
		for (i = 0; i < RAM_WORDS; i++) begin
			@(negedge clk);
			dbg_addr = addr_t'(i) << 2;
			dbg_req = 1'b1;
			do
				@(negedge clk);
			while (!dbg_ack);
			check_word($sformatf("readback word %0d", i), model_mem[i], dbg_rdata);
			dbg_req = 1'b0;
		end
		finish_test();
	endtask

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the run did not finish", cycles);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		set_idle();
		op_a = '0;
		op_b = '0;
		acc = '0;
		base = '0;
		count = reg_cnt_t'(1);
		st_data = '0;
		dbg_req = 1'b0;
		dbg_addr = '0;
		words_done = 0;
		mul_cycles = 0;
		hold_left = 0;
		n_issued = 0;
		instr_active = 1'b0;
		test_errs = 0;
		total_errs = 0;
		n_tests = 0;
		n_failed = 0;
		exp_prod = '0;
		exp_cyc = '0;
		exp_cyc.issue = 1'b1;

		repeat (10) @(negedge clk);
		test_name = "reset";
		check_cycle("reset cycle", exp_cyc, cycle);
		if (rd_valid || st_take || base_wb_valid || dbg_ack)
			report_error("a handshake output is high during reset");
		finish_test();
		rst_n = 1'b1;

		do
			run_cycle();
		while (instr_active || dbg_req);
		read_back();

		$display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, total_errs);
		if (n_failed == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== logic/core_exec_top.sv ====
`timescale 1ns/100ps

module core_exec_top #(
	parameter int RAM_AW = core_pkg::RAM_AW,
	parameter int MUL_STEPS = core_pkg::MUL_STEPS
) (
	input logic clk,
	input logic rst_n,
	input logic halt,
	input logic mul,
	input logic ldst,
	input logic bubble,
	input logic exception,
	input logic mul_add,
	input logic mul_long,
	input logic trivial_shift,
	input logic ldst_writeback,
	input logic data_snd_shift_by_reg,
	input core_pkg::word_t op_a,
	input core_pkg::word_t op_b,
	input core_pkg::dword_t acc,
	input logic load,
	input core_pkg::addr_t base,
	input core_pkg::reg_cnt_t count,
	input core_pkg::word_t st_data,
	input logic dbg_req,
	input core_pkg::addr_t dbg_addr,
	output core_pkg::ctrl_cycle cycle,
	output core_pkg::dword_t product,
	output logic rd_valid,
	output core_pkg::word_t rd_data,
	output logic st_take,
	output logic base_wb_valid,
	output core_pkg::addr_t base_wb_data,
	output logic dbg_ack,
	output core_pkg::word_t dbg_rdata
);
	import core_pkg::*;

	ctrl_cycle next_cycle;
	logic mul_ready;
	logic pop_valid;
	logic ram_en;
	logic ram_we;
	ram_addr_t ram_addr;
	word_t ram_wdata;
	word_t ram_rdata;

	mem_bus_if ldst_bus ();
	mem_bus_if dbg_bus ();

	// Debug port only reads
	assign dbg_bus.req = dbg_req;
	assign dbg_bus.we = 1'b0;
	assign dbg_bus.addr = dbg_addr;
	assign dbg_bus.wdata = '0;
	assign dbg_ack = dbg_bus.ready;
	assign dbg_rdata = dbg_bus.rdata;

	core_cycles i_core_cycles (
		.clk, .rst_n, .halt, .mul, .ldst, .bubble, .exception,
		.mem_ready(ldst_bus.ready), .mul_add, .mul_long, .mul_ready, .pop_valid,
		.trivial_shift, .ldst_writeback, .data_snd_shift_by_reg,
		.cycle, .next_cycle
	);

	core_mul #(.MUL_STEPS(MUL_STEPS)) i_core_mul (
		.clk, .rst_n, .op_a, .op_b, .acc, .mul_add, .cycle, .next_cycle,
		.mul_ready, .product
	);

	core_ldst #(.RAM_AW(RAM_AW)) i_core_ldst (
		.clk, .rst_n, .cycle, .next_cycle, .load, .base, .count, .st_data,
		.ldst_bus(ldst_bus.master), .pop_valid, .rd_valid, .st_take, .rd_data,
		.base_wb_valid, .base_wb_data
	);

	mem_arbiter #(.RAM_AW(RAM_AW)) i_mem_arbiter (
		.clk, .rst_n, .ldst_bus(ldst_bus.arbiter), .dbg_bus(dbg_bus.arbiter),
		.ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
	);

	data_ram #(.RAM_AW(RAM_AW)) i_data_ram (
		.clk, .en(ram_en), .we(ram_we), .addr(ram_addr), .wdata(ram_wdata),
		.rdata(ram_rdata)
	);

endmodule

// ==== logic/core_cycles.sv ====
`timescale 1ns/100ps

module core_cycles (
	input logic clk,
	input logic rst_n,
	input logic halt,
	input logic mul,
	input logic ldst,
	input logic bubble,
	input logic exception,
	input logic mem_ready,
	input logic mul_add,
	input logic mul_long,
	input logic mul_ready,
	input logic pop_valid,
	input logic trivial_shift,
	input logic ldst_writeback,
	input logic data_snd_shift_by_reg,
	output core_pkg::ctrl_cycle cycle,
	output core_pkg::ctrl_cycle next_cycle
);

	typedef enum logic [3:0] {
		ST_ISSUE,
		ST_RD_INDIRECT_SHIFT,
		ST_WITH_SHIFT,
		ST_TRANSFER,
		ST_BASE_WRITEBACK,
		ST_EXCEPTION,
		ST_MUL,
		ST_MUL_ACC_LD,
		ST_MUL_HI_WB
	} state_t;

	state_t state;
	state_t next_state;

	// Flags of the current cycle come from the state register
	assign cycle = '{
		issue: state == ST_ISSUE,
		rd_indirect_shift: state == ST_RD_INDIRECT_SHIFT,
		with_shift: state == ST_WITH_SHIFT,
		transfer: state == ST_TRANSFER,
		base_writeback: state == ST_BASE_WRITEBACK,
		exception: state == ST_EXCEPTION,
		mul: state == ST_MUL,
		mul_acc_ld: state == ST_MUL_ACC_LD,
		mul_hi_wb: state == ST_MUL_HI_WB
	};

	// The units look ahead at these to start on the entry edge
	assign next_cycle = '{
		issue: next_state == ST_ISSUE,
		rd_indirect_shift: next_state == ST_RD_INDIRECT_SHIFT,
		with_shift: next_state == ST_WITH_SHIFT,
		transfer: next_state == ST_TRANSFER,
		base_writeback: next_state == ST_BASE_WRITEBACK,
		exception: next_state == ST_EXCEPTION,
		mul: next_state == ST_MUL,
		mul_acc_ld: next_state == ST_MUL_ACC_LD,
		mul_hi_wb: next_state == ST_MUL_HI_WB
	};

	always_comb begin
		// Any state without a rule falls back to issue
		next_state = ST_ISSUE;
		case (state)
			ST_ISSUE: begin
				// Exception has priority over everything else at issue
				if (exception)
					next_state = ST_EXCEPTION;
				else if (halt)
					next_state = ST_ISSUE;
				else if (mul)
					next_state = mul_add ? ST_MUL_ACC_LD : ST_MUL;
				else if (data_snd_shift_by_reg)
					next_state = ST_RD_INDIRECT_SHIFT;
				else if (!trivial_shift)
					next_state = ST_WITH_SHIFT;
			end
			ST_RD_INDIRECT_SHIFT: begin
				if (!trivial_shift)
					next_state = ST_WITH_SHIFT;
			end
			ST_TRANSFER: begin
				// Stay until the last word has been acknowledged
				if (!mem_ready || pop_valid)
					next_state = ST_TRANSFER;
				else if (ldst_writeback)
					next_state = ST_BASE_WRITEBACK;
			end
			ST_MUL: begin
				if (!mul_ready)
					next_state = ST_MUL;
				else if (mul_long)
					next_state = ST_MUL_HI_WB;
			end
			ST_MUL_ACC_LD:
				next_state = ST_MUL;
			default: ;
		endcase

		// A bubble always returns to issue, a pending load/store diverts it
		if (bubble)
			next_state = ST_ISSUE;
		else if (next_state == ST_ISSUE && ldst)
			next_state = ST_TRANSFER;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= ST_ISSUE;
		else
			state <= next_state;
	end

endmodule

// ==== logic/core_ldst.sv ====
`timescale 1ns/100ps

module core_ldst #(
	parameter int RAM_AW = core_pkg::RAM_AW
) (
	input logic clk,
	input logic rst_n,
	input core_pkg::ctrl_cycle cycle,
	input core_pkg::ctrl_cycle next_cycle,
	input logic load,
	input core_pkg::addr_t base,
	input core_pkg::reg_cnt_t count,
	input core_pkg::word_t st_data,
	mem_bus_if.master ldst_bus,
	output logic pop_valid,
	output logic rd_valid,
	output logic st_take,
	output core_pkg::word_t rd_data,
	output logic base_wb_valid,
	output core_pkg::addr_t base_wb_data
);
	import core_pkg::*;

	logic busy;
	logic start;
	logic is_store;
	reg_cnt_t rem;
	reg_cnt_t cnt_q;
	addr_t base_q;
	// Word pointer inside the RAM window, it wraps with the RAM size
	logic [RAM_AW-1:0] word_ptr;

	assign start = next_cycle.transfer && !cycle.transfer;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			rem <= '0;
		end else if (start) begin
			busy <= 1'b1;
			rem <= count;
		end else if (busy && ldst_bus.ready) begin
			rem <= rem - 1'b1;
			if (rem == reg_cnt_t'(1))
				busy <= 1'b0;
		end
	end

	// Instruction operands latched on entry, pointer steps per acknowledged word
	always_ff @(posedge clk) begin
		if (start) begin
			base_q <= base;
			cnt_q <= count;
			is_store <= !load;
			word_ptr <= base[RAM_AW+1:2];
		end else if (busy && ldst_bus.ready) begin
			word_ptr <= word_ptr + 1'b1;
		end
	end

	// One request stays up for every word still pending
	assign ldst_bus.req = busy;
	assign ldst_bus.we = is_store;
	assign ldst_bus.addr = {base_q[ADDR_W-1:RAM_AW+2], word_ptr, 2'b00};
	assign ldst_bus.wdata = st_data;

	// More words follow the one in flight
	assign pop_valid = busy && (rem > reg_cnt_t'(1));

	assign rd_valid = ldst_bus.ready && !is_store;
	assign st_take = ldst_bus.ready && is_store;
	assign rd_data = ldst_bus.rdata;

	assign base_wb_valid = cycle.base_writeback;
	assign base_wb_data = base_q + addr_t'({cnt_q, 2'b00});

endmodule

// ==== logic/core_mul.sv ====
`timescale 1ns/100ps

module core_mul #(
	parameter int MUL_STEPS = core_pkg::MUL_STEPS
) (
	input logic clk,
	input logic rst_n,
	input core_pkg::word_t op_a,
	input core_pkg::word_t op_b,
	input core_pkg::dword_t acc,
	input logic mul_add,
	input core_pkg::ctrl_cycle cycle,
	input core_pkg::ctrl_cycle next_cycle,
	output logic mul_ready,
	output core_pkg::dword_t product
);
	import core_pkg::*;

	// Multiplier bits retired on each clock
	localparam int BITS = WORD_W / MUL_STEPS;
	localparam int STEP_W = $clog2(MUL_STEPS + 1);

	logic busy;
	logic done;
	logic [STEP_W-1:0] step;
	logic start;
	dword_t mcand;
	dword_t acc_q;
	dword_t partial;
	word_t mplier;

	// Start on entry to mul from any other state
	assign start = next_cycle.mul && !cycle.mul;
	assign mul_ready = done && cycle.mul;

	// Shift-and-add over the low BITS multiplier bits
	always_comb begin
		partial = '0;
		for (int i = 0; i < BITS; i++) begin
			if (mplier[i])
				partial = partial + (mcand << i);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			step <= '0;
		end else if (start) begin
			busy <= 1'b1;
			done <= 1'b0;
			step <= '0;
		end else if (busy) begin
			step <= step + 1'b1;
			// The last step completes the product
			if (step == STEP_W'(MUL_STEPS - 1)) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		// Accumulator is captured on entry to mul_acc_ld
		if (next_cycle.mul_acc_ld)
			acc_q <= acc;
		if (start) begin
			mcand <= dword_t'(op_a);
			mplier <= op_b;
			product <= (mul_add && cycle.mul_acc_ld) ? acc_q : '0;
		end else if (busy) begin
			mcand <= mcand << BITS;
			mplier <= mplier >> BITS;
			product <= product + partial;
		end
	end

endmodule

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/100ps

module mem_arbiter #(
	parameter int RAM_AW = core_pkg::RAM_AW
) (
	input logic clk,
	input logic rst_n,
	mem_bus_if.arbiter ldst_bus,
	mem_bus_if.arbiter dbg_bus,
	output logic ram_en,
	output logic ram_we,
	output core_pkg::ram_addr_t ram_addr,
	output core_pkg::word_t ram_wdata,
	input core_pkg::word_t ram_rdata
);
	import core_pkg::*;

	logic resp_q;
	logic owner_dbg;
	logic last_dbg;
	logic gnt_ldst;
	logic gnt_dbg;

	// No grant in the response cycle, the debug port wins a tie after a load/store grant
	always_comb begin
		gnt_ldst = 1'b0;
		gnt_dbg = 1'b0;
		if (!resp_q) begin
			if (ldst_bus.req && (!dbg_bus.req || last_dbg))
				gnt_ldst = 1'b1;
			else if (dbg_bus.req)
				gnt_dbg = 1'b1;
		end
	end

	assign ram_en = gnt_ldst || gnt_dbg;
	assign ram_we = gnt_dbg ? dbg_bus.we : (gnt_ldst && ldst_bus.we);
	assign ram_addr = gnt_dbg ? ram_addr_t'(dbg_bus.addr[RAM_AW+1:2]) :
		ram_addr_t'(ldst_bus.addr[RAM_AW+1:2]);
	assign ram_wdata = gnt_dbg ? dbg_bus.wdata : ldst_bus.wdata;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			resp_q <= 1'b0;
			owner_dbg <= 1'b0;
			last_dbg <= 1'b0;
		end else begin
			resp_q <= ram_en;
			if (ram_en) begin
				owner_dbg <= gnt_dbg;
				last_dbg <= gnt_dbg;
			end
		end
	end

	// Response goes only to the port that held the grant
	assign ldst_bus.ready = resp_q && !owner_dbg;
	assign dbg_bus.ready = resp_q && owner_dbg;
	assign ldst_bus.rdata = owner_dbg ? '0 : ram_rdata;
	assign dbg_bus.rdata = owner_dbg ? ram_rdata : '0;

endmodule

// ==== logic/data_ram.sv ====
`timescale 1ns/100ps

module data_ram #(
	parameter int RAM_AW = core_pkg::RAM_AW
) (
	input logic clk,
	input logic en,
	input logic we,
	input core_pkg::ram_addr_t addr,
	input core_pkg::word_t wdata,
	output core_pkg::word_t rdata
);
	import core_pkg::*;

	localparam int DEPTH = 2 ** RAM_AW;

	word_t mem [DEPTH];

	// Registered read, a write returns the old word in the same access
	always_ff @(posedge clk) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;
			rdata <= mem[addr];
		end
	end

endmodule

// ==== logic/mem_bus_if.sv ====
`timescale 1ns/100ps

interface mem_bus_if;
	import core_pkg::*;

	// Request side, held stable by the master until ready
	logic req;
	logic we;
	addr_t addr;
	word_t wdata;

	// Response side, ready pulses one clock after the grant
	word_t rdata;
	logic ready;

	modport master (
		output req, we, addr, wdata,
		input rdata, ready
	);

	modport arbiter (
		input req, we, addr, wdata,
		output rdata, ready
	);

endinterface

// ==== logic/core_pkg.sv ====
package core_pkg;

	// Datapath and memory bus widths
	localparam int WORD_W = 32;
	localparam int DWORD_W = 2 * WORD_W;
	localparam int ADDR_W = 32;
	localparam int CNT_W = 5;

	// Default RAM depth as a word index width, overridden from the top level
	localparam int RAM_AW = 6;

	// Default number of multiplier iterations
	localparam int MUL_STEPS = 4;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [DWORD_W-1:0] dword_t;

	// Byte address, the two low bits stay zero for word accesses
	typedef logic [ADDR_W-1:0] addr_t;

	// Word index into the data RAM
	typedef logic [RAM_AW-1:0] ram_addr_t;

	// Words moved by one load/store instruction, 1 to 16
	typedef logic [CNT_W-1:0] reg_cnt_t;

	// One-hot execute cycle, exactly one flag is set at a time
	typedef struct packed {
		logic issue;
		logic rd_indirect_shift;
		logic with_shift;
		logic transfer;
		logic base_writeback;
		logic exception;
		logic mul;
		logic mul_acc_ld;
		logic mul_hi_wb;
	} ctrl_cycle;

endpackage
